// File: div_data_pkg.sv
package div_data_pkg;

  localparam int CHUNK_W  = 6;
  localparam int N_CHUNKS = 8;

  typedef logic [N_CHUNKS*CHUNK_W-1:0] operand_t;   // 48-bit unsigned dividend
  typedef logic [47:0]                 quot_t;
  typedef logic [CHUNK_W-1:0]          rem_t;       // divisor is at most 63
  typedef logic [3:0]                  tag_t;

  // code 2'd3 has no name and is rejected by decode
  typedef enum logic [1:0] {
    OP_DIV    = 2'd0,
    OP_MOD    = 2'd1,
    OP_DIVMOD = 2'd2
  } div_op_e;

  typedef enum logic {
    ST_OK     = 1'b0,
    ST_BAD_OP = 1'b1
  } div_status_e;

  typedef struct packed {
    div_op_e  op;
    tag_t     tag;
    operand_t operand;
  } div_cmd_s;                                      // 54 bits

  typedef struct packed {
    div_op_e                          op;
    tag_t                             tag;
    logic                             legal;
    logic [N_CHUNKS-1:0][CHUNK_W-1:0] chunks;       // chunks[0] is the least significant
  } div_job_s;                                      // 55 bits

  typedef struct packed {
    tag_t        tag;
    div_status_e status;
    quot_t       quot;
    rem_t        rem;
  } div_res_s;                                      // 59 bits

endpackage

// File: div_flow_pkg.sv
package div_flow_pkg;

  localparam int CREDIT_W = 4;

  typedef logic [CREDIT_W-1:0] credit_t;

  typedef enum logic [1:0] {
    BUF_EMPTY,
    BUF_PART,
    BUF_FULL
  } buf_state_e;

  // occupancy class of a buffer holding count of depth entries
  function automatic buf_state_e occupancy(int unsigned count, int unsigned depth);
    if (count == 0) begin
      return BUF_EMPTY;
    end
    if (count >= depth) begin
      return BUF_FULL;
    end
    return BUF_PART;
  endfunction

endpackage

// File: div_cmd_decode.sv
`timescale 1ns/1ps

module div_cmd_decode #(
  parameter int IN_DEPTH = 4
) (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   cmd_valid,
  input  div_data_pkg::div_cmd_s cmd,
  output logic                   cmd_credit,
  input  logic                   exec_ready,
  output logic                   job_valid,
  output div_data_pkg::div_job_s job
);

  localparam int PTR_W = (IN_DEPTH > 1) ? $clog2(IN_DEPTH) : 1;
  localparam int CNT_W = $clog2(IN_DEPTH + 1);

  div_data_pkg::div_cmd_s   fifo_mem [IN_DEPTH];
  div_data_pkg::div_cmd_s   head;
  logic [PTR_W-1:0]         wr_ptr;
  logic [PTR_W-1:0]         rd_ptr;
  logic [CNT_W-1:0]         count;
  div_flow_pkg::buf_state_e state;
  logic                     push;
  logic                     pop;

  function automatic logic [PTR_W-1:0] next_ptr(logic [PTR_W-1:0] p);
    return (p == PTR_W'(IN_DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign state = div_flow_pkg::occupancy(count, IN_DEPTH);
  assign head  = fifo_mem[rd_ptr];

  assign pop  = exec_ready && (state != div_flow_pkg::BUF_EMPTY);
  assign push = cmd_valid && ((state != div_flow_pkg::BUF_FULL) || pop); // no credit, no room

  always_ff @(posedge clk) begin
    if (push) begin
      fifo_mem[wr_ptr] <= cmd;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      cmd_credit <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      count      <= count + CNT_W'(push) - CNT_W'(pop);
      cmd_credit <= pop;                            // entry freed, credit back to sender
    end
  end

  // ##########################################################################
  // job issue

  assign job_valid = pop;

  always_comb begin
    job.op     = head.op;
    job.tag    = head.tag;
    job.legal  = head.op inside {div_data_pkg::OP_DIV, div_data_pkg::OP_MOD,
                                 div_data_pkg::OP_DIVMOD};
    job.chunks = head.operand;                      // same bits, seen as 6-bit chunks
  end

endmodule

// File: div_chunk_exec.sv
`timescale 1ns/1ps

module div_chunk_exec #(
  parameter int DIVISOR = 47
) (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   job_valid,
  input  div_data_pkg::div_job_s job,
  output logic                   res_valid_x,
  output div_data_pkg::div_res_s res_x
);

  localparam int CHUNK_W  = div_data_pkg::CHUNK_W;
  localparam int N_CHUNKS = div_data_pkg::N_CHUNKS;
  localparam int N_VALUES = 1 << CHUNK_W;
  localparam int RSUM_W   = $clog2(N_CHUNKS * DIVISOR); // sum of 8 residues below DIVISOR
  localparam int FOLD_W   = $clog2(N_CHUNKS);           // fold quotient is below 8

  // c * 64**k split into DIVISOR * quotient + residue
  function automatic div_data_pkg::quot_t part_quot(int k, int c);
    div_data_pkg::operand_t v;
    v = div_data_pkg::operand_t'(c) << (CHUNK_W * k);
    return div_data_pkg::quot_t'(v / DIVISOR);
  endfunction

  function automatic div_data_pkg::rem_t part_rem(int k, int c);
    div_data_pkg::operand_t v;
    v = div_data_pkg::operand_t'(c) << (CHUNK_W * k);
    return div_data_pkg::rem_t'(v % DIVISOR);
  endfunction

  div_data_pkg::quot_t tab_quot [N_CHUNKS][N_VALUES];
  div_data_pkg::rem_t  tab_rem  [N_CHUNKS][N_VALUES];

  for (genvar k = 0; k < N_CHUNKS; k++) begin : g_pos
    for (genvar c = 0; c < N_VALUES; c++) begin : g_val
      localparam div_data_pkg::quot_t PQ = part_quot(k, c);
      localparam div_data_pkg::rem_t  PR = part_rem(k, c);
      assign tab_quot[k][c] = PQ;
      assign tab_rem[k][c]  = PR;
    end
  end

  // ##########################################################################
  // stage 1: table lookup and column sums

  div_data_pkg::quot_t qsum;
  logic [RSUM_W-1:0]   rsum;

  logic                s1_valid;
  logic                s1_legal;
  div_data_pkg::tag_t  s1_tag;
  div_data_pkg::quot_t s1_qsum;
  logic [RSUM_W-1:0]   s1_rsum;

  always_comb begin
    qsum = '0;
    rsum = '0;
    for (int k = 0; k < N_CHUNKS; k++) begin
      qsum = qsum + tab_quot[k][job.chunks[k]];
      rsum = rsum + RSUM_W'(tab_rem[k][job.chunks[k]]);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= job_valid;
    end
  end

  always_ff @(posedge clk) begin
    s1_legal <= job.legal;
    s1_tag   <= job.tag;
    s1_qsum  <= qsum;
    s1_rsum  <= rsum;
  end

  // ##########################################################################
  // stage 2: residue fold and quotient correction

  logic [FOLD_W-1:0] fold_q;
  logic [RSUM_W-1:0] fold_r;

  always_comb begin
    fold_q = '0;
    for (int j = 1; j < N_CHUNKS; j++) begin
      if (s1_rsum >= RSUM_W'(j * DIVISOR)) begin
        fold_q = FOLD_W'(j);
      end
    end
    fold_r = s1_rsum - RSUM_W'(fold_q * DIVISOR);
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      res_valid_x <= 1'b0;
    end else begin
      res_valid_x <= s1_valid;
    end
  end

  always_ff @(posedge clk) begin
    res_x.tag <= s1_tag;
    if (s1_legal) begin
      res_x.status <= div_data_pkg::ST_OK;
      res_x.quot   <= s1_qsum + div_data_pkg::quot_t'(fold_q);
      res_x.rem    <= div_data_pkg::rem_t'(fold_r);
    end else begin
      res_x.status <= div_data_pkg::ST_BAD_OP;    // no arithmetic for a bad opcode
      res_x.quot   <= '0;
      res_x.rem    <= '0;
    end
  end

endmodule

// File: div_result_fmt.sv
`timescale 1ns/1ps

module div_result_fmt #(
  parameter int OUT_CREDITS = 4,
  parameter int DIVISOR     = 47
) (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   job_valid,
  input  div_data_pkg::div_op_e  job_op,
  input  logic                   res_valid_x,
  input  div_data_pkg::div_res_s res_x,
  output logic                   exec_ready,
  input  logic                   res_credit,
  output logic                   res_valid,
  output div_data_pkg::div_res_s res
);

  localparam int EXEC_LAT  = 2;
  localparam int RES_DEPTH = OUT_CREDITS + EXEC_LAT;  // covers the execute latency
  localparam int PTR_W     = $clog2(RES_DEPTH);
  localparam int CNT_W     = $clog2(RES_DEPTH + 1);
  localparam int OP_DEPTH  = 2 * EXEC_LAT;
  localparam int OP_PTR_W  = $clog2(OP_DEPTH);

  // ##########################################################################
  // op side FIFO whose occupancy is the in-flight job count

  div_data_pkg::div_op_e op_mem [OP_DEPTH];
  logic [OP_PTR_W-1:0]   op_wr;
  logic [OP_PTR_W-1:0]   op_rd;
  logic [OP_PTR_W:0]     op_count;
  div_data_pkg::div_op_e cur_op;

  assign cur_op = op_mem[op_rd];

  always_ff @(posedge clk) begin
    if (job_valid) begin
      op_mem[op_wr] <= job_op;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      op_wr    <= '0;
      op_rd    <= '0;
      op_count <= '0;
    end else begin
      if (job_valid) begin
        op_wr <= op_wr + 1'b1;
      end
      if (res_valid_x) begin
        op_rd <= op_rd + 1'b1;
      end
      op_count <= op_count + (OP_PTR_W+1)'(job_valid) - (OP_PTR_W+1)'(res_valid_x);
    end
  end

  // ##########################################################################
  // opcode masking and result buffer

  div_data_pkg::div_res_s   fmt;
  div_data_pkg::div_res_s   rbuf [RES_DEPTH];
  logic [PTR_W-1:0]         wr_ptr;
  logic [PTR_W-1:0]         rd_ptr;
  logic [CNT_W-1:0]         res_count;
  div_flow_pkg::buf_state_e rstate;
  div_flow_pkg::credit_t    credit_cnt;

  function automatic logic [PTR_W-1:0] next_ptr(logic [PTR_W-1:0] p);
    return (p == PTR_W'(RES_DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  always_comb begin
    fmt = res_x;
    case (cur_op)
      div_data_pkg::OP_DIV: fmt.rem  = '0;
      div_data_pkg::OP_MOD: fmt.quot = '0;
      default: ;                                    // divmod keeps both and a bad op is already zero
    endcase
  end

  always_ff @(posedge clk) begin
    if (res_valid_x) begin
      rbuf[wr_ptr] <= fmt;
    end
  end

  assign rstate    = div_flow_pkg::occupancy(res_count, RES_DEPTH);
  assign res       = rbuf[rd_ptr];
  assign res_valid = (rstate != div_flow_pkg::BUF_EMPTY) && (credit_cnt != '0);

  // buffered results plus jobs still in execute must fit in the buffer
  assign exec_ready = (int'(res_count) + int'(op_count)) < RES_DEPTH;

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      res_count  <= '0;
      credit_cnt <= div_flow_pkg::CREDIT_W'(OUT_CREDITS);
    end else begin
      if (res_valid_x) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (res_valid) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      res_count  <= res_count + CNT_W'(res_valid_x) - CNT_W'(res_valid);
      credit_cnt <= credit_cnt + div_flow_pkg::credit_t'(res_credit)
                    - div_flow_pkg::credit_t'(res_valid);
    end
  end

endmodule

// File: const_div_top.sv
`timescale 1ns/1ps

module const_div_top #(
  parameter int DIVISOR     = 47,
  parameter int IN_DEPTH    = 4,
  parameter int OUT_CREDITS = 4
) (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   cmd_valid,
  input  div_data_pkg::div_cmd_s cmd,
  output logic                   cmd_credit,
  output logic                   res_valid,
  output div_data_pkg::div_res_s res,
  input  logic                   res_credit
);

  logic                   exec_ready;
  logic                   job_valid;
  div_data_pkg::div_job_s job;
  logic                   res_valid_x;
  div_data_pkg::div_res_s res_x;

  div_cmd_decode #(
    .IN_DEPTH   (IN_DEPTH)
  ) u_decode (
    .clk        (clk),
    .rst        (rst),
    .cmd_valid  (cmd_valid),
    .cmd        (cmd),
    .cmd_credit (cmd_credit),
    .exec_ready (exec_ready),
    .job_valid  (job_valid),
    .job        (job)
  );

  div_chunk_exec #(
    .DIVISOR     (DIVISOR)
  ) u_exec (
    .clk         (clk),
    .rst         (rst),
    .job_valid   (job_valid),
    .job         (job),
    .res_valid_x (res_valid_x),
    .res_x       (res_x)
  );

  div_result_fmt #(
    .OUT_CREDITS (OUT_CREDITS),
    .DIVISOR     (DIVISOR)
  ) u_result (
    .clk         (clk),
    .rst         (rst),
    .job_valid   (job_valid),
    .job_op      (job.op),                        // op rides beside execute
    .res_valid_x (res_valid_x),
    .res_x       (res_x),
    .exec_ready  (exec_ready),
    .res_credit  (res_credit),
    .res_valid   (res_valid),
    .res         (res)
  );

endmodule

// File: tb_const_div_assert.sv
`timescale 1ns/1ps

module tb_const_div_assert #(
  parameter int OUT_CREDITS = 4
) (
  input logic                  clk,
  input logic                  rst,
  input logic                  res_valid,
  input logic                  res_credit,
  input logic                  exec_ready,
  input div_flow_pkg::credit_t credit_cnt
);

  int model_cr;                                     // credits the receiver has granted

  always_ff @(posedge clk) begin
    if (rst) begin
      model_cr <= OUT_CREDITS;
    end else begin
      model_cr <= model_cr + int'(res_credit) - int'(res_valid);
    end
  end

  // ##########################################################################
  // output credit rules

  a_valid_needs_credit: assert property (
    @(posedge clk) disable iff (rst) res_valid |-> (model_cr != 0)
  ) else $error("res_valid high while the receiver granted no output credit");

  a_credit_bound: assert property (
    @(posedge clk) disable iff (rst) int'(credit_cnt) <= OUT_CREDITS
  ) else $error("output credit count %0d above its reset value", credit_cnt);

  // buffer and in-flight count are both empty out of reset
  a_ready_after_reset: assert property (
    @(posedge clk) rst |=> exec_ready
  ) else $error("exec_ready low right after reset");

endmodule

bind div_result_fmt tb_const_div_assert #(
  .OUT_CREDITS (OUT_CREDITS)
) u_assert (
  .clk        (clk),
  .rst        (rst),
  .res_valid  (res_valid),
  .res_credit (res_credit),
  .exec_ready (exec_ready),
  .credit_cnt (credit_cnt)
);

// File: tb_const_div.sv
`timescale 1ns/1ps

module tb_const_div;

  localparam int DIVISOR     = 47;
  localparam int IN_DEPTH    = 4;
  localparam int OUT_CREDITS = 4;
  localparam int CLK_HALF    = 20;
  localparam int RST_CYCLES  = 16;
  localparam int N_EDGE      = 36;
  localparam int N_RAND      = 300;
  localparam int N_BAD       = 100;
  localparam int N_STALL     = 60;
  localparam int N_FILL      = 2 * OUT_CREDITS + 2 + IN_DEPTH; // sent, buffered, queued
  localparam int N_CMDS      = N_EDGE + N_RAND + N_BAD + N_STALL + N_FILL;

  logic                   clk        = 1'b0;
  logic                   rst        = 1'b1;
  logic                   cmd_valid  = 1'b0;
  div_data_pkg::div_cmd_s cmd        = '0;
  logic                   res_credit = 1'b0;
  logic                   cmd_credit;
  logic                   res_valid;
  div_data_pkg::div_res_s res;

  div_data_pkg::div_res_s exp_q [$];
  logic [16:0]            stim_lfsr    = 17'd85191;
  logic [16:0]            gap_lfsr     = 17'd85191;
  logic                   hold_credits = 1'b0;
  logic                   long_gaps    = 1'b0;
  div_data_pkg::tag_t     next_tag     = '0;
  int                     in_credits   = IN_DEPTH;
  int                     owed;
  int                     out_cr;
  int                     gap;
  int                     n_checked    = 0;
  int                     n_errors     = 0;

  always #(CLK_HALF) clk = ~clk;

  const_div_top #(
    .DIVISOR     (DIVISOR),
    .IN_DEPTH    (IN_DEPTH),
    .OUT_CREDITS (OUT_CREDITS)
  ) DUT (
    .clk        (clk),
    .rst        (rst),
    .cmd_valid  (cmd_valid),
    .cmd        (cmd),
    .cmd_credit (cmd_credit),
    .res_valid  (res_valid),
    .res        (res),
    .res_credit (res_credit)
  );

  // x^17 + x^14 + 1
  function automatic logic [16:0] lfsr_next(logic [16:0] s);
    return {s[15:0], s[16] ^ s[13]};
  endfunction

  task automatic take_bits(input int n, inout logic [16:0] s, output logic [47:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      s = lfsr_next(s);
      v = {v[46:0], s[0]};
    end
  endtask

  function automatic div_data_pkg::div_res_s ref_div(div_data_pkg::div_cmd_s c);
    div_data_pkg::div_res_s r;
    r.tag    = c.tag;
    r.status = div_data_pkg::ST_OK;
    r.quot   = c.operand / div_data_pkg::operand_t'(DIVISOR);
    r.rem    = div_data_pkg::rem_t'(c.operand % div_data_pkg::operand_t'(DIVISOR));
    case (c.op)
      div_data_pkg::OP_DIV:    r.rem  = '0;
      div_data_pkg::OP_MOD:    r.quot = '0;
      div_data_pkg::OP_DIVMOD: ;
      default: begin
        r.status = div_data_pkg::ST_BAD_OP;
        r.quot   = '0;
        r.rem    = '0;
      end
    endcase
    return r;
  endfunction

  task automatic check_quot(input div_data_pkg::quot_t got, input div_data_pkg::quot_t want);
    if (got !== want) begin
      $display("FAIL res.quot got 0x%h expected 0x%h", got, want);
      n_errors++;
    end
  endtask

  task automatic check_rem(input div_data_pkg::rem_t got, input div_data_pkg::rem_t want);
    if (got !== want) begin
      $display("FAIL res.rem got 0x%h expected 0x%h", got, want);
      n_errors++;
    end
  endtask

  task automatic check_tag(input div_data_pkg::tag_t got, input div_data_pkg::tag_t want);
    if (got !== want) begin
      $display("FAIL res.tag got 0x%h expected 0x%h", got, want);
      n_errors++;
    end
  endtask

  task automatic check_status(input div_data_pkg::div_status_e got,
                              input div_data_pkg::div_status_e want);
    if (got !== want) begin
      $display("FAIL res.status got 0x%h expected 0x%h", got, want);
      n_errors++;
    end
  endtask

  // ##########################################################################
  // command side, every wait goes through tick so input credits are never missed

  task automatic tick();
    @(posedge clk);
    cmd_valid <= 1'b0;
    if (cmd_credit) begin
      in_credits++;
    end
  endtask

  task automatic send_cmd(input div_data_pkg::div_op_e op, input div_data_pkg::operand_t v);
    div_data_pkg::div_cmd_s c;
    tick();
    while (in_credits == 0) begin
      tick();
    end
    c = '{op: op, tag: next_tag, operand: v};
    cmd_valid <= 1'b1;
    cmd       <= c;
    in_credits--;
    next_tag++;
    exp_q.push_back(ref_div(c));
  endtask

  task automatic rand_traffic(input int n, input bit legal_only);
    logic [47:0] v;
    logic [1:0]  op;
    for (int i = 0; i < n; i++) begin
      take_bits(2, stim_lfsr, v);
      while (legal_only && v[1:0] == 2'd3) begin
        take_bits(2, stim_lfsr, v);                 // redraw the illegal code
      end
      op = v[1:0];
      take_bits(48, stim_lfsr, v);
      send_cmd(div_data_pkg::div_op_e'(op), v);
    end
  endtask

  task automatic drain();
    while (exp_q.size() != 0 || owed != 0) begin
      tick();
    end
    repeat (2) tick();                              // last credit lands in the DUT
  endtask

  task automatic report_test(input int num, input string name, input int chk0, input int err0);
    $display("test %0d %s: %0d results, %0d errors", num, name,
             n_checked - chk0, n_errors - err0);
  endtask

  // ##########################################################################
  // result side: compare, model the DUT credit count, return credits

  always @(posedge clk) begin
    div_data_pkg::div_res_s want;
    logic [47:0]            v;
    if (rst) begin
      res_credit <= 1'b0;
      owed   = 0;
      out_cr = OUT_CREDITS;
      gap    = 0;
    end else begin
      if (res_valid) begin
        if (out_cr == 0) begin
          $display("result sent while the DUT held no output credit");
          n_errors++;
        end
        if (exp_q.size() == 0) begin
          $display("result arrived with no command outstanding");
          n_errors++;
        end else begin
          want = exp_q.pop_front();
          check_tag(res.tag, want.tag);             // tags give the order
          check_status(res.status, want.status);
          check_quot(res.quot, want.quot);
          check_rem(res.rem, want.rem);
          n_checked++;
        end
        owed++;
      end
      out_cr = out_cr + int'(res_credit) - int'(res_valid);
      res_credit <= 1'b0;
      if (owed > 0 && !hold_credits) begin
        if (gap == 0) begin
          res_credit <= 1'b1;
          owed--;
          take_bits(long_gaps ? 6 : 2, gap_lfsr, v);
          gap = int'(v[5:0]);
        end else begin
          gap--;
        end
      end
    end
  end

  initial begin
    int chk0;
    int err0;
    repeat (RST_CYCLES) @(posedge clk);
    rst <= 1'b0;

    chk0 = n_checked;
    err0 = n_errors;
    for (int o = 0; o < 3; o++) begin
      send_cmd(div_data_pkg::div_op_e'(o), '0);
      send_cmd(div_data_pkg::div_op_e'(o), div_data_pkg::operand_t'(DIVISOR - 1));
      send_cmd(div_data_pkg::div_op_e'(o), div_data_pkg::operand_t'(DIVISOR));
      send_cmd(div_data_pkg::div_op_e'(o), '1);
      for (int k = 0; k < div_data_pkg::N_CHUNKS; k++) begin
        send_cmd(div_data_pkg::div_op_e'(o), div_data_pkg::operand_t'(1) << (6 * k));
      end
    end
    drain();
    report_test(1, "edge operands", chk0, err0);

    chk0 = n_checked;
    err0 = n_errors;
    rand_traffic(N_RAND, 1'b1);
    drain();
    report_test(2, "random legal", chk0, err0);

    chk0 = n_checked;
    err0 = n_errors;
    rand_traffic(N_BAD, 1'b0);
    drain();
    report_test(3, "illegal opcode mix", chk0, err0);

    chk0 = n_checked;
    err0 = n_errors;
    long_gaps <= 1'b1;
    rand_traffic(N_STALL, 1'b1);
    drain();
    long_gaps <= 1'b0;
    report_test(4, "output back-pressure", chk0, err0);

    chk0 = n_checked;
    err0 = n_errors;
    hold_credits <= 1'b1;
    rand_traffic(N_FILL, 1'b1);
    repeat (40) tick();
    if (in_credits != 0) begin
      $display("input credit returned while the output was stalled (%0d held)", in_credits);
      n_errors++;
    end
    hold_credits <= 1'b0;
    drain();
    report_test(5, "input buffer fill", chk0, err0);

    $display("summary: 5 tests, %0d results checked, %0d errors", n_checked, n_errors);
    if (n_errors == 0 && exp_q.size() == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  initial begin
    #((N_CMDS * 200 + RST_CYCLES) * 2 * CLK_HALF);
    $display("timeout: the run did not finish within %0d cycles", N_CMDS * 200 + RST_CYCLES);
    $display("TEST FAILED");
    $finish;
  end

endmodule

// File: const_div_top.f
div_data_pkg.sv
div_flow_pkg.sv
div_cmd_decode.sv
div_chunk_exec.sv
div_result_fmt.sv
const_div_top.sv
tb_const_div_assert.sv
tb_const_div.sv

// File: Makefile
TOP = tb_const_div

sim:
	verilator --binary --timing --assert -Wno-fatal -f const_div_top.f --top-module $(TOP) -o $(TOP)
	@out=$$(./obj_dir/$(TOP)); echo "$$out"; echo "$$out" | grep -q "TEST PASSED"

clean:
	rm -rf obj_dir

.PHONY: sim clean
